/* hdl/minerPkg.sv */
package minerPkg;

    typedef logic [31:0] word_t;
    // word 0 sits in the top bits, as in the byte order of the standard
    typedef word_t [0:7] digest_t;
    typedef word_t [0:15] block_t;

    // sha-256 round constants
    localparam word_t roundK [64] = '{
        32'h428a2f98, 32'h71374491, 32'hb5c0fbcf, 32'he9b5dba5,
        32'h3956c25b, 32'h59f111f1, 32'h923f82a4, 32'hab1c5ed5,
        32'hd807aa98, 32'h12835b01, 32'h243185be, 32'h550c7dc3,
        32'h72be5d74, 32'h80deb1fe, 32'h9bdc06a7, 32'hc19bf174,
        32'he49b69c1, 32'hefbe4786, 32'h0fc19dc6, 32'h240ca1cc,
        32'h2de92c6f, 32'h4a7484aa, 32'h5cb0a9dc, 32'h76f988da,
        32'h983e5152, 32'ha831c66d, 32'hb00327c8, 32'hbf597fc7,
        32'hc6e00bf3, 32'hd5a79147, 32'h06ca6351, 32'h14292967,
        32'h27b70a85, 32'h2e1b2138, 32'h4d2c6dfc, 32'h53380d13,
        32'h650a7354, 32'h766a0abb, 32'h81c2c92e, 32'h92722c85,
        32'ha2bfe8a1, 32'ha81a664b, 32'hc24b8b70, 32'hc76c51a3,
        32'hd192e819, 32'hd6990624, 32'hf40e3585, 32'h106aa070,
        32'h19a4c116, 32'h1e376c08, 32'h2748774c, 32'h34b0bcb5,
        32'h391c0cb3, 32'h4ed8aa4a, 32'h5b9cca4f, 32'h682e6ff3,
        32'h748f82ee, 32'h78a5636f, 32'h84c87814, 32'h8cc70208,
        32'h90befffa, 32'ha4506ceb, 32'hbef9a3f7, 32'hc67178f2
    };

    // standard initial hash value
    localparam digest_t sha256Iv = '{
        32'h6a09e667, 32'hbb67ae85, 32'h3c6ef372, 32'ha54ff53a,
        32'h510e527f, 32'h9b05688c, 32'h1f83d9ab, 32'h5be0cd19
    };

    // byte offsets of the register map
    localparam logic [7:0] RegControl = 8'h00;
    localparam logic [7:0] RegStatus = 8'h04;
    localparam logic [7:0] RegStartNonce = 8'h08;
    localparam logic [7:0] RegEndNonce = 8'h0c;
    localparam logic [7:0] RegTarget = 8'h10;
    localparam logic [7:0] RegFoundNonce = 8'h14;
    localparam logic [7:0] RegFoundWord = 8'h18;
    // eight midstate words from here
    localparam logic [7:0] RegMidstate = 8'h20;
    // sixteen block words from here
    localparam logic [7:0] RegBlock = 8'h40;

endpackage

/* hdl/hashLaneIf.sv */
`timescale 1ns/100ps

interface hashLaneIf import minerPkg::*; ();
    // one-cycle pulse, digest word 0 met the target
    logic hit;
    // tested nonce and its digest word 0, valid with hit
    word_t hitNonce;
    word_t hitWord;
    // level, lane ran past the end nonce
    logic exhausted;
    // level from the arbiter, lane stops after its current compression
    logic halt;

    modport lane (
        output hit, hitNonce, hitWord, exhausted,
        input halt
    );

    modport arbiter (
        input hit, hitNonce, hitWord, exhausted,
        output halt
    );
endinterface

/* hdl/sha256Core.sv */
`timescale 1ns/100ps

module sha256Core import minerPkg::*; (
    input logic clock,
    input logic reset,
    input logic start,
    input digest_t midstate,
    input block_t block,
    output logic done,
    output digest_t digest
);

    logic running;
    // 0..63 rounds, 64 means final add
    logic [6:0] round;
    // working variables a..h
    digest_t work;
    // message schedule, window[0] is the word used this round
    block_t window;
    word_t sum0, sum1, choose, majority, temp1, temp2, sched;

    function automatic word_t rotr(word_t x, int unsigned n);
        return (x >> n) | (x << (32 - n));
    endfunction

    function automatic word_t smallSigma0(word_t x);
        return rotr(x, 7) ^ rotr(x, 18) ^ (x >> 3);
    endfunction

    function automatic word_t smallSigma1(word_t x);
        return rotr(x, 17) ^ rotr(x, 19) ^ (x >> 10);
    endfunction

    // one round of the compression function
    always_comb begin
        sum1 = rotr(work[4], 6) ^ rotr(work[4], 11) ^ rotr(work[4], 25);
        choose = (work[4] & work[5]) ^ (~work[4] & work[6]);
        temp1 = work[7] + sum1 + choose + roundK[round[5:0]] + window[0];
        sum0 = rotr(work[0], 2) ^ rotr(work[0], 13) ^ rotr(work[0], 22);
        majority = (work[0] & work[1]) ^ (work[0] & work[2]) ^ (work[1] & work[2]);
        temp2 = sum0 + majority;
        // W[t+16] from the sliding window
        sched = smallSigma1(window[14]) + window[9] + smallSigma0(window[1]) + window[0];
    end

    // sequencing, start only taken while idle
    always_ff @(posedge clock) begin
        if (reset) begin
            running <= 1'b0;
            done <= 1'b0;
            round <= '0;
        end else begin
            done <= 1'b0;
            if (!running) begin
                if (start) begin
                    running <= 1'b1;
                    round <= '0;
                end
            end else if (round[6]) begin
                // final add happens on this edge
                running <= 1'b0;
                done <= 1'b1;
            end else begin
                round <= round + 7'd1;
            end
        end
    end

    // datapath
    always_ff @(posedge clock) begin
        if (!running && start) begin
            work <= midstate;
            window <= block;
        end else if (running && !round[6]) begin
            work <= {temp1 + temp2, work[0:2], work[3] + temp1, work[4:6]};
            window <= {window[1:15], sched};
        end else if (running && round[6]) begin
            // feed-forward of the chaining value
            for (int i = 0; i < 8; i++) begin
                digest[i] <= work[i] + midstate[i];
            end
        end
    end

endmodule

/* hdl/nonceLane.sv */
`timescale 1ns/100ps

module nonceLane import minerPkg::*; #(
    parameter int unsigned NonceStep = 2,
    parameter int unsigned LaneIndex = 0
) (
    input logic clock,
    input logic reset,
    input logic launch,
    input digest_t midstate,
    input block_t block,
    input word_t target,
    input word_t startNonce,
    input word_t endNonce,
    hashLaneIf.lane laneBus
);

    word_t nonce;
    logic searching, startPending, coreActive, discard;
    logic coreStart, coreDone, resultValid, meetsTarget, lastNonce;
    logic [32:0] firstNonce, nextNonce;
    block_t coreBlock;
    digest_t coreDigest;

    // carry bit marks a wrap past the top of the nonce space
    assign firstNonce = {1'b0, startNonce} + 33'(LaneIndex);
    assign nextNonce = {1'b0, nonce} + 33'(NonceStep);
    assign lastNonce = nextNonce[32] || (nextNonce[31:0] > endNonce);
    assign meetsTarget = coreDigest[0] <= target;

    // core may still be busy with a stopped search
    assign coreStart = startPending && !coreActive;
    // digest that belongs to the running search
    assign resultValid = coreDone && searching && !discard && !laneBus.halt && !launch;

    // nonce goes into block word 3
    always_comb begin
        coreBlock = block;
        coreBlock[3] = nonce;
    end

    sha256Core core (
        .clock(clock),
        .reset(reset),
        .start(coreStart),
        .midstate(midstate),
        .block(coreBlock),
        .done(coreDone),
        .digest(coreDigest)
    );

    always_ff @(posedge clock) begin
        if (reset) begin
            searching <= 1'b0;
            startPending <= 1'b0;
            coreActive <= 1'b0;
            discard <= 1'b0;
            laneBus.hit <= 1'b0;
            laneBus.exhausted <= 1'b0;
        end else begin
            laneBus.hit <= 1'b0;
            if (coreStart) begin
                coreActive <= 1'b1;
                startPending <= 1'b0;
            end else if (coreDone) begin
                coreActive <= 1'b0;
            end
            if (launch) begin
                // a compression still in flight is from the old search
                discard <= coreActive && !coreDone;
                laneBus.exhausted <= 1'b0;
                if (firstNonce[32] || firstNonce[31:0] > endNonce) begin
                    // range too short for this lane
                    searching <= 1'b0;
                    startPending <= 1'b0;
                    laneBus.exhausted <= 1'b1;
                end else begin
                    searching <= 1'b1;
                    startPending <= 1'b1;
                end
            end else if (coreDone) begin
                discard <= 1'b0;
                if (laneBus.halt) begin
                    searching <= 1'b0;
                end else if (resultValid) begin
                    if (meetsTarget) begin
                        laneBus.hit <= 1'b1;
                        searching <= 1'b0;
                    end else if (lastNonce) begin
                        laneBus.exhausted <= 1'b1;
                        searching <= 1'b0;
                    end else begin
                        startPending <= 1'b1;
                    end
                end
            end
        end
    end

    // nonce and result payload
    always_ff @(posedge clock) begin
        if (launch) begin
            nonce <= firstNonce[31:0];
        end else if (resultValid) begin
            nonce <= nextNonce[31:0];
        end
        if (coreDone) begin
            laneBus.hitNonce <= nonce;
            laneBus.hitWord <= coreDigest[0];
        end
    end

endmodule

/* hdl/foundArbiter.sv */
`timescale 1ns/100ps

module foundArbiter import minerPkg::*; (
    input logic clock,
    input logic reset,
    input logic launch,
    input logic stop,
    hashLaneIf.arbiter lane0,
    hashLaneIf.arbiter lane1,
    output logic busy,
    output logic found,
    output logic exhausted,
    output word_t foundNonce,
    output word_t foundWord
);

    logic halt, takeHit, allExhausted;

    // both lanes halt together
    assign lane0.halt = halt;
    assign lane1.halt = halt;

    // first hit of the search only
    assign takeHit = busy && (lane0.hit || lane1.hit) && !stop && !launch;
    assign allExhausted = lane0.exhausted && lane1.exhausted;

    always_ff @(posedge clock) begin
        if (reset) begin
            busy <= 1'b0;
            found <= 1'b0;
            exhausted <= 1'b0;
            halt <= 1'b0;
        end else if (stop) begin
            // stop wins over a launch in the same write
            busy <= 1'b0;
            halt <= 1'b1;
        end else if (launch) begin
            busy <= 1'b1;
            found <= 1'b0;
            exhausted <= 1'b0;
            halt <= 1'b0;
        end else if (takeHit) begin
            busy <= 1'b0;
            found <= 1'b1;
            halt <= 1'b1;
        end else if (busy && allExhausted) begin
            busy <= 1'b0;
            exhausted <= 1'b1;
            halt <= 1'b1;
        end
    end

    // even lane holds the lower nonce of a compression
    always_ff @(posedge clock) begin
        if (takeHit) begin
            foundNonce <= lane0.hit ? lane0.hitNonce : lane1.hitNonce;
            foundWord <= lane0.hit ? lane0.hitWord : lane1.hitWord;
        end
    end

endmodule

/* hdl/minerRegs.sv */
`timescale 1ns/100ps

module minerRegs import minerPkg::*; #(
    parameter int unsigned AddrWidth = 7
) (
    input logic clock,
    input logic reset,
    input logic [AddrWidth-1:0] awaddr,
    input logic awvalid,
    output logic awready,
    input word_t wdata,
    input logic [3:0] wstrb,
    input logic wvalid,
    output logic wready,
    output logic [1:0] bresp,
    output logic bvalid,
    input logic bready,
    input logic [AddrWidth-1:0] araddr,
    input logic arvalid,
    output logic arready,
    output word_t rdata,
    output logic [1:0] rresp,
    output logic rvalid,
    input logic rready,
    input logic found,
    input logic exhausted,
    input logic busy,
    input word_t foundNonce,
    input word_t foundWord,
    output logic launch,
    output logic stop,
    output digest_t midstate,
    output block_t block,
    output word_t target,
    output word_t startNonce,
    output word_t endNonce
);

    logic writeFire, readFire, cfgWrite, ctrlWrite;
    logic [7:0] wrOffset, rdOffset;
    word_t readWord;

    function automatic word_t mergeBytes(word_t oldWord, word_t newWord, logic [3:0] strobe);
        word_t merged;
        merged = oldWord;
        for (int i = 0; i < 4; i++) begin
            if (strobe[i]) begin
                merged[8*i +: 8] = newWord[8*i +: 8];
            end
        end
        return merged;
    endfunction

    assign wrOffset = 8'(awaddr);
    assign rdOffset = 8'(araddr);

    // address and data accepted together, one write in flight
    assign awready = awvalid && wvalid && !bvalid;
    assign wready = awready;
    assign writeFire = awready;
    assign arready = !rvalid;
    assign readFire = arvalid && arready;
    assign bresp = 2'b00;
    assign rresp = 2'b00;

    // configuration frozen during a search
    assign cfgWrite = writeFire && !busy;
    assign ctrlWrite = writeFire && (wrOffset == RegControl) && wstrb[0];

    always_ff @(posedge clock) begin
        if (reset) begin
            bvalid <= 1'b0;
            rvalid <= 1'b0;
            launch <= 1'b0;
            stop <= 1'b0;
        end else begin
            // control bits are self-clearing pulses
            launch <= ctrlWrite && wdata[0];
            stop <= ctrlWrite && wdata[1];
            if (writeFire) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
            if (readFire) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (cfgWrite) begin
            if (wrOffset == RegStartNonce) begin
                startNonce <= mergeBytes(startNonce, wdata, wstrb);
            end
            if (wrOffset == RegEndNonce) begin
                endNonce <= mergeBytes(endNonce, wdata, wstrb);
            end
            if (wrOffset == RegTarget) begin
                target <= mergeBytes(target, wdata, wstrb);
            end
            if ((wrOffset & 8'he0) == RegMidstate) begin
                midstate[wrOffset[4:2]] <= mergeBytes(midstate[wrOffset[4:2]], wdata, wstrb);
            end
            if ((wrOffset & 8'hc0) == RegBlock) begin
                block[wrOffset[5:2]] <= mergeBytes(block[wrOffset[5:2]], wdata, wstrb);
            end
        end
    end

    // read mux, control reads as zero
    always_comb begin
        readWord = '0;
        if ((rdOffset & 8'he0) == RegMidstate) begin
            readWord = midstate[rdOffset[4:2]];
        end else if ((rdOffset & 8'hc0) == RegBlock) begin
            readWord = block[rdOffset[5:2]];
        end else begin
            case (rdOffset)
                RegStatus: readWord = {29'b0, exhausted, found, busy};
                RegStartNonce: readWord = startNonce;
                RegEndNonce: readWord = endNonce;
                RegTarget: readWord = target;
                RegFoundNonce: readWord = foundNonce;
                RegFoundWord: readWord = foundWord;
                default: readWord = '0;
            endcase
        end
    end

    // held until rready
    always_ff @(posedge clock) begin
        if (readFire) begin
            rdata <= readWord;
        end
    end

endmodule

/* hdl/minerTop.sv */
`timescale 1ns/100ps

module minerTop import minerPkg::*; #(
    parameter int unsigned AddrWidth = 7,
    parameter int unsigned NonceStep = 2
) (
    input logic clock,
    input logic reset,
    input logic [AddrWidth-1:0] awaddr,
    input logic awvalid,
    output logic awready,
    input word_t wdata,
    input logic [3:0] wstrb,
    input logic wvalid,
    output logic wready,
    output logic [1:0] bresp,
    output logic bvalid,
    input logic bready,
    input logic [AddrWidth-1:0] araddr,
    input logic arvalid,
    output logic arready,
    output word_t rdata,
    output logic [1:0] rresp,
    output logic rvalid,
    input logic rready
);

    logic launch, stop, busy, found, exhausted;
    digest_t midstate;
    block_t block;
    word_t target, startNonce, endNonce, foundNonce, foundWord;

    // one result bus per lane
    hashLaneIf lane0Bus ();
    hashLaneIf lane1Bus ();

    minerRegs #(.AddrWidth(AddrWidth)) regs (
        .clock(clock), .reset(reset),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
        .bresp(bresp), .bvalid(bvalid), .bready(bready),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
        .found(found), .exhausted(exhausted), .busy(busy),
        .foundNonce(foundNonce), .foundWord(foundWord),
        .launch(launch), .stop(stop), .midstate(midstate), .block(block),
        .target(target), .startNonce(startNonce), .endNonce(endNonce)
    );

    // even lane
    nonceLane #(.NonceStep(NonceStep), .LaneIndex(0)) lane0 (
        .clock(clock), .reset(reset), .launch(launch),
        .midstate(midstate), .block(block), .target(target),
        .startNonce(startNonce), .endNonce(endNonce), .laneBus(lane0Bus.lane)
    );

    // odd lane
    nonceLane #(.NonceStep(NonceStep), .LaneIndex(1)) lane1 (
        .clock(clock), .reset(reset), .launch(launch),
        .midstate(midstate), .block(block), .target(target),
        .startNonce(startNonce), .endNonce(endNonce), .laneBus(lane1Bus.lane)
    );

    foundArbiter arbiter (
        .clock(clock), .reset(reset), .launch(launch), .stop(stop),
        .lane0(lane0Bus.arbiter), .lane1(lane1Bus.arbiter),
        .busy(busy), .found(found), .exhausted(exhausted),
        .foundNonce(foundNonce), .foundWord(foundWord)
    );

endmodule

/* verification/minerTb_assert.sv */
`timescale 1ns/100ps

module minerTbAssert import minerPkg::*; (
    input logic clock,
    input logic reset,
    input logic bvalid,
    input logic bready,
    input logic rvalid,
    input logic rready,
    input word_t rdata,
    input logic busy,
    input logic found,
    input logic exhausted,
    input word_t foundNonce,
    input word_t foundWord,
    input word_t startNonce,
    input word_t midstateWord,
    input word_t blockWord
);

    // failures so far, the testbench reads this at the end
    int failCount = 0;

    // write response held until bready
    bHeld: assert property (@(posedge clock) disable iff (reset)
        bvalid && !bready |=> bvalid)
        else begin
            $error("bvalid dropped before bready");
            failCount++;
        end

    // read response and its data held until rready
    rHeld: assert property (@(posedge clock) disable iff (reset)
        rvalid && !rready |=> rvalid && $stable(rdata))
        else begin
            $error("rvalid or rdata changed before rready");
            failCount++;
        end

    // a search ends one way only
    resultsExclusive: assert property (@(posedge clock) disable iff (reset)
        !(found && exhausted))
        else begin
            $error("found and exhausted high together");
            failCount++;
        end

    // result flags only while idle
    idleAtEnd: assert property (@(posedge clock) disable iff (reset)
        found || exhausted |-> !busy)
        else begin
            $error("busy still high after the search ended");
            failCount++;
        end

    // winner never below the first nonce of the range
    lowestNonce: assert property (@(posedge clock) disable iff (reset)
        $rose(found) |-> foundNonce >= startNonce)
        else begin
            $error("found nonce below the start nonce");
            failCount++;
        end

    // "abc" from the standard iv, nonce 0 is block word 3 = 0
    knownDigest: assert property (@(posedge clock) disable iff (reset)
        $rose(found) && startNonce == 0 && foundNonce == 0
            && midstateWord == sha256Iv[0] && blockWord == 32'h61626380
        |-> foundWord == 32'hba7816bf)
        else begin
            $error("digest word 0 of the known block is wrong");
            failCount++;
        end

endmodule

/* verification/minerTb.sv */
`timescale 1ns/100ps

module minerTb import minerPkg::*; ();

    // handshake wait limit in cycles
    localparam int Timeout = 2000;
    // status reads allowed per search
    localparam int PollLimit = 400;

    logic clock, reset;
    logic [6:0] awaddr, araddr;
    logic awvalid, wvalid, bready, arvalid, rready;
    logic awready, wready, bvalid, arready, rvalid;
    logic [3:0] wstrb;
    logic [1:0] bresp, rresp;
    word_t wdata, rdata;

    int errorCount = 0;
    int timeoutCount = 0;

    minerTop #(.AddrWidth(7), .NonceStep(2)) dut (.*);

    bind minerTop minerTbAssert checks (
        .clock(clock), .reset(reset),
        .bvalid(bvalid), .bready(bready), .rvalid(rvalid), .rready(rready), .rdata(rdata),
        .busy(busy), .found(found), .exhausted(exhausted),
        .foundNonce(foundNonce), .foundWord(foundWord), .startNonce(startNonce),
        .midstateWord(midstate[0]), .blockWord(block[0])
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    function automatic logic [7:0] cfgOffset(int index);
        // start, end, target, then midstate and block words
        if (index < 3) begin
            return RegStartNonce + 8'(4 * index);
        end else if (index < 11) begin
            return RegMidstate + 8'(4 * (index - 3));
        end
        return RegBlock + 8'(4 * (index - 11));
    endfunction

    task automatic checkWord(input string name, input word_t expected, input word_t actual);
        if (expected !== actual) begin
            errorCount++;
            $display("[ERROR] %0t %s expected %h actual %h", $time, name, expected, actual);
        end
    endtask

    task automatic writeReg(input logic [7:0] offset, input word_t data,
                            input logic [3:0] strobe = 4'hf);
        int cycles;
        logic accepted;
        logic dataReady;
        logic [1:0] response;
        @(posedge clock);
        awaddr <= offset[6:0];
        wdata <= data;
        wstrb <= strobe;
        awvalid <= 1'b1;
        wvalid <= 1'b1;
        cycles = 0;
        accepted = 1'b0;
        dataReady = 1'b0;
        while (!accepted && cycles < Timeout) begin
            @(posedge clock);
            accepted = awready;
            dataReady = wready;
            cycles++;
        end
        awvalid <= 1'b0;
        wvalid <= 1'b0;
        if (!accepted) begin
            timeoutCount++;
            $display("timeout at %0t: write to %h was never accepted", $time, offset);
            return;
        end
        // data channel taken in the same cycle as the address
        checkWord("wready", 32'h1, 32'(dataReady));
        // response held back a few cycles
        repeat ($urandom % 5) @(posedge clock);
        bready <= 1'b1;
        cycles = 0;
        accepted = 1'b0;
        response = '0;
        while (!accepted && cycles < Timeout) begin
            @(posedge clock);
            accepted = bvalid;
            response = bresp;
            cycles++;
        end
        bready <= 1'b0;
        if (!accepted) begin
            timeoutCount++;
            $display("timeout at %0t: no write response for %h", $time, offset);
        end else begin
            // okay response only
            checkWord("bresp", 32'h0, 32'(response));
        end
    endtask

    task automatic readReg(input logic [7:0] offset, output word_t data);
        int cycles;
        logic accepted;
        logic [1:0] response;
        data = '0;
        @(posedge clock);
        araddr <= offset[6:0];
        arvalid <= 1'b1;
        cycles = 0;
        accepted = 1'b0;
        while (!accepted && cycles < Timeout) begin
            @(posedge clock);
            accepted = arready;
            cycles++;
        end
        arvalid <= 1'b0;
        if (!accepted) begin
            timeoutCount++;
            $display("timeout at %0t: read of %h was never accepted", $time, offset);
            return;
        end
        repeat ($urandom % 5) @(posedge clock);
        rready <= 1'b1;
        cycles = 0;
        accepted = 1'b0;
        response = '0;
        while (!accepted && cycles < Timeout) begin
            @(posedge clock);
            accepted = rvalid;
            data = rdata;
            response = rresp;
            cycles++;
        end
        rready <= 1'b0;
        if (!accepted) begin
            timeoutCount++;
            $display("timeout at %0t: no read data for %h", $time, offset);
        end else begin
            checkWord("rresp", 32'h0, 32'(response));
        end
    endtask

    // polls status until busy clears
    task automatic waitIdle(output word_t finalStatus);
        int polls;
        polls = 0;
        do begin
            readReg(RegStatus, finalStatus);
            polls++;
        end while (finalStatus[0] && polls < PollLimit);
        if (finalStatus[0]) begin
            timeoutCount++;
            $display("timeout at %0t: search never went idle", $time);
        end
    endtask

    // "abc" padded into one block whose word 3 later carries the nonce
    task automatic runKnownAnswer();
        word_t value;
        for (int i = 0; i < 8; i++) begin
            writeReg(RegMidstate + 8'(4 * i), sha256Iv[i]);
        end
        for (int i = 0; i < 16; i++) begin
            value = (i == 0) ? 32'h61626380 : (i == 15) ? 32'h00000018 : 32'h0;
            writeReg(RegBlock + 8'(4 * i), value);
        end
        writeReg(RegStartNonce, 32'h0);
        writeReg(RegEndNonce, 32'h0);
        writeReg(RegTarget, 32'hffffffff);
        writeReg(RegControl, 32'h1);
        waitIdle(value);
        checkWord("status", 32'h2, value);
        readReg(RegFoundNonce, value);
        checkWord("foundNonce", 32'h0, value);
        readReg(RegFoundWord, value);
        checkWord("foundWord", 32'hba7816bf, value);
    endtask

    initial begin
        word_t written [27];
        word_t value, first, second, start;
        void'($urandom(53290));
        reset = 1'b1;
        awaddr = '0;
        awvalid = 1'b0;
        wdata = '0;
        wstrb = '0;
        wvalid = 1'b0;
        bready = 1'b0;
        araddr = '0;
        arvalid = 1'b0;
        rready = 1'b0;
        repeat (16) @(posedge clock);
        reset <= 1'b0;

        // configuration read-back
        for (int i = 0; i < 27; i++) begin
            written[i] = $urandom;
            writeReg(cfgOffset(i), written[i]);
        end
        for (int i = 0; i < 27; i++) begin
            readReg(cfgOffset(i), value);
            checkWord($sformatf("register %02h", cfgOffset(i)), written[i], value);
        end
        // bytes 0 and 2 only
        first = $urandom;
        second = $urandom;
        writeReg(RegTarget, first);
        writeReg(RegTarget, second, 4'b0101);
        readReg(RegTarget, value);
        checkWord("target", (first & 32'hff00ff00) | (second & 32'h00ff00ff), value);

        runKnownAnswer();

        // both lanes hit at once and the even lane must win
        start = $urandom & 32'h7ffffffe;
        writeReg(RegStartNonce, start);
        writeReg(RegEndNonce, start + 32'd9);
        writeReg(RegTarget, 32'hffffffff);
        writeReg(RegControl, 32'h1);
        waitIdle(value);
        checkWord("status", 32'h2, value);
        readReg(RegFoundNonce, value);
        checkWord("foundNonce", start, value);

        // six nonces where no digest can meet target 0
        start = $urandom & 32'h7ffffffe;
        writeReg(RegStartNonce, start);
        writeReg(RegEndNonce, start + 32'd5);
        writeReg(RegTarget, 32'h0);
        writeReg(RegControl, 32'h1);
        waitIdle(value);
        checkWord("status", 32'h4, value);

        // long search stopped part way
        writeReg(RegStartNonce, 32'h0);
        writeReg(RegEndNonce, 32'hffffffff);
        writeReg(RegControl, 32'h1);
        repeat (300) @(posedge clock);
        readReg(RegStatus, value);
        checkWord("status", 32'h1, value);
        writeReg(RegControl, 32'h2);
        waitIdle(value);
        checkWord("status", 32'h0, value);
        // writes land again once idle
        first = $urandom;
        writeReg(RegTarget, first);
        readReg(RegTarget, value);
        checkWord("target", first, value);
        runKnownAnswer();

        $display("errors %0d, timeouts %0d, assertion failures %0d",
                 errorCount, timeoutCount, dut.checks.failCount);
        if (errorCount == 0 && timeoutCount == 0 && dut.checks.failCount == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

/* flist.f */
hdl/minerPkg.sv
hdl/hashLaneIf.sv
hdl/sha256Core.sv
hdl/nonceLane.sv
hdl/foundArbiter.sv
hdl/minerRegs.sv
hdl/minerTop.sv
verification/minerTb_assert.sv
verification/minerTb.sv

/* Makefile */
SIM := obj_dir/VminerTb

.PHONY: run clean

# rebuilt only when the file list or a source changes
$(SIM): flist.f $(shell cat flist.f)
	verilator --binary --timing --assert -Wno-fatal -j 0 --top-module minerTb -f flist.f

# pass or fail is decided by the log
run: $(SIM)
	./$(SIM) +verilator+error+limit+1000 | tee sim.log
	grep -q "\*\*\* PASSED \*\*\*" sim.log

clean:
	rm -rf obj_dir sim.log
